// File: sources.f
tetris_geom_pkg.sv
tetris_ctrl_pkg.sv
board_if.sv
game_fsm.sv
piece_tracker.sv
playfield.sv
tetris_top.sv
tetris_sva.sv
tb_tetris.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_tetris -f sources.f -o tb_tetris
./obj_dir/tb_tetris 2>&1 | tee sim.log
if grep -q "=== PASS ===" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: tb_tetris.sv
// Falling block game testbench
`timescale 1ns/1ps

module tb_tetris;
    import tetris_geom_pkg::*;
    import tetris_ctrl_pkg::*;

    logic        clk;
    logic        reset;
    logic        tick_i;
    logic        left_i;
    logic        right_i;
    logic        spawn_o;
    logic        gameover_o;
    score_t      score_o;
    piece_type_t piece_type_o;
    field_t      display_o;

    // Reference model state
    field_t      model_field;
    score_t      model_score;
    int          piece_idx;
    logic        exp_over;
    logic [31:0] rng;

    tetris_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic piece_type_t seq_type(int idx);
        return piece_type_t'(idx % 7);
    endfunction

    // Cells of a shape at a box position, ok drops when a cell leaves the board
    function automatic field_t shape_at(piece_type_t kind, int r, int c, output logic ok);
        field_t m;
        m  = '0;
        ok = 1'b1;
        for (int dr = 0; dr < SHAPE_SIZE; dr++) begin
            for (int dc = 0; dc < SHAPE_SIZE; dc++) begin
                if (SHAPES[kind][dr][dc]) begin
                    if (r + dr >= BOARD_ROWS || c + dc < 0 || c + dc >= BOARD_COLS) begin
                        ok = 1'b0;
                    end else begin
                        m[r + dr][c + dc] = 1'b1;
                    end
                end
            end
        end
        return m;
    endfunction

    function automatic logic fits(field_t f, piece_type_t kind, int r, int c);
        field_t m;
        logic   ok;
        m = shape_at(kind, r, c, ok);
        return ok && !(|(m & f));
    endfunction

    // One lateral bit pair per tick, the stuck tick included
    function automatic field_t drop_piece(field_t f, piece_type_t kind,
                                          logic [31:0] lefts, logic [31:0] rights);
        int   r;
        int   c;
        logic go_left;
        logic go_right;
        logic ok;
        r = 0;
        c = SPAWN_COL;
        for (int k = 0; k < 32; k++) begin
            if (!fits(f, kind, r + 1, c)) begin
                break;
            end
            // Sideways moves judged at the row before the step
            go_left  = lefts[k] && fits(f, kind, r, c - 1);
            go_right = rights[k] && fits(f, kind, r, c + 1);
            r++;
            if (go_left) begin
                c--;
            end else if (go_right) begin
                c++;
            end
        end
        return shape_at(kind, r, c, ok);
    endfunction

    function automatic field_t clear_lines(field_t f, output int n);
        int r;
        n = 0;
        r = BOARD_ROWS - 1;
        while (r >= 0) begin
            if (&f[r]) begin
                for (int k = r; k > 0; k--) begin
                    f[k] = f[k - 1];
                end
                f[0] = '0;
                n++;
            end else begin
                r--;
            end
        end
        return f;
    endfunction

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_field(string name, field_t exp, field_t act);
        if (act !== exp) begin
            report_failure($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_score(string name, score_t exp, score_t act);
        if (act !== exp) begin
            report_failure($sformatf("[ERROR] %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_type(string name, piece_type_t exp, piece_type_t act);
        if (act !== exp) begin
            report_failure($sformatf("[ERROR] %s: expected %s, actual %s", name,
                                     exp.name(), act.name()));
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            report_failure($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // One tick strobe, then seven quiet cycles
    task automatic tick_once(logic l, logic r);
        tick_i  = 1'b1;
        left_i  = l;
        right_i = r;
        @(negedge clk);
        tick_i  = 1'b0;
        left_i  = 1'b0;
        right_i = 1'b0;
        repeat (7) @(negedge clk);
    endtask

    task automatic apply_reset();
        reset   = 1'b1;
        tick_i  = 1'b0;
        left_i  = 1'b0;
        right_i = 1'b0;
        repeat (3) @(negedge clk);
        reset       = 1'b0;
        model_field = '0;
        model_score = '0;
        piece_idx   = 0;
        @(negedge clk);
    endtask

    task automatic play_piece(string name, logic [31:0] lefts, logic [31:0] rights);
        field_t landed;
        field_t spawn_mask;
        logic   ok;
        int     lines;
        int     ticks;
        // Top row is tested before the merge
        exp_over = |model_field[0];
        if (!exp_over) begin
            landed      = model_field | drop_piece(model_field, seq_type(piece_idx), lefts, rights);
            model_field = clear_lines(landed, lines);
            if (int'(model_score) + lines > int'(SCORE_MAX)) begin
                model_score = SCORE_MAX;
            end else begin
                model_score = score_t'(int'(model_score) + lines);
            end
            piece_idx++;
        end
        check_flag({name, " spawn ready"}, 1'b1, spawn_o);
        tick_once(1'b0, 1'b0);
        ticks = 0;
        while (!spawn_o && !gameover_o) begin
            if (ticks == 32) begin
                report_failure({name, ": timeout, neither spawn nor game over came back"});
            end else begin
                tick_once(lefts[ticks], rights[ticks]);
                ticks++;
            end
        end
        check_flag({name, " game over"}, exp_over, gameover_o);
        check_flag({name, " spawn"}, !exp_over, spawn_o);
        check_score({name, " score"}, model_score, score_o);
        if (exp_over) begin
            check_field({name, " display"}, model_field, display_o);
        end else begin
            spawn_mask = shape_at(seq_type(piece_idx), 0, SPAWN_COL, ok);
            check_field({name, " display"}, model_field | spawn_mask, display_o);
            check_type({name, " type"}, seq_type(piece_idx), piece_type_o);
        end
    endtask

    initial begin
        logic [31:0] lefts;
        logic [31:0] rights;
        logic        ok;
        int          shifts [7];
        int          count;
        reset   = 1'b1;
        tick_i  = 1'b0;
        left_i  = 1'b0;
        right_i = 1'b0;
        rng     = 32'd86;
        apply_reset();

        check_flag("reset spawn", 1'b1, spawn_o);
        check_flag("reset gameover", 1'b0, gameover_o);
        check_score("reset score", '0, score_o);
        check_type("reset type", LINE, piece_type_o);
        check_field("reset display", shape_at(LINE, 0, SPAWN_COL, ok), display_o);

        // Column offsets that complete the bottom row
        shifts = '{-4, -3, -1, 1, -4, -1, 3};
        for (int i = 0; i < 7; i++) begin
            lefts  = (shifts[i] < 0) ? (32'd1 << (-shifts[i])) - 32'd1 : '0;
            rights = (shifts[i] > 0) ? (32'd1 << shifts[i]) - 32'd1 : '0;
            play_piece($sformatf("clear piece %0d", i), lefts, rights);
        end
        check_score("line clear score", 8'd1, score_o);

        play_piece("left wall", '1, '0);
        play_piece("right wall", '0, '1);
        for (int i = 0; i < 3; i++) begin
            play_piece($sformatf("plain drop %0d", i), '0, '0);
        end

        apply_reset();
        for (int i = 0; i < 12; i++) begin
            rng    = xorshift(rng);
            lefts  = rng;
            rng    = xorshift(rng);
            rights = rng;
            play_piece($sformatf("random piece %0d", i), lefts, rights);
            if (exp_over) begin
                break;
            end
        end

        // Centre stack until the top row fills
        apply_reset();
        count    = 0;
        exp_over = 1'b0;
        while (!exp_over) begin
            if (count == 24) begin
                report_failure("Game over was not reached after 24 stacked pieces");
            end else begin
                play_piece($sformatf("stack piece %0d", count), '0, '0);
                count++;
            end
        end
        for (int i = 0; i < 3; i++) begin
            tick_once(1'b1, 1'b0);
        end
        check_flag("held gameover", 1'b1, gameover_o);
        check_flag("held spawn", 1'b0, spawn_o);
        check_score("held score", model_score, score_o);
        check_field("held display", model_field, display_o);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: tetris_sva.sv
// State and score assertions
`timescale 1ns/1ps

module tetris_sva (
    input logic                         clk,
    input logic                         reset,
    input tetris_ctrl_pkg::game_state_t state_i,
    input logic                         eval_done_i,
    input tetris_ctrl_pkg::score_t      score_i
);
    import tetris_ctrl_pkg::*;

    score_no_drop: assert property (@(posedge clk) disable iff (reset)
        score_i >= $past(score_i))
        else $error("score went down without reset");

    done_in_eval: assert property (@(posedge clk) disable iff (reset)
        eval_done_i |-> state_i == EVAL)
        else $error("eval_done high outside EVAL");

    over_sticks: assert property (@(posedge clk) disable iff (reset)
        state_i == GAMEOVER |=> state_i == GAMEOVER)
        else $error("GAMEOVER left while reset is low");

endmodule

bind playfield tetris_sva i_sva_field (
    .clk         (clk),
    .reset       (reset),
    .state_i     (state_i),
    .eval_done_i (eval_done_o),
    .score_i     (score_o)
);

// File: tetris_top.sv
// Falling block game top level
`timescale 1ns/1ps

module tetris_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         tick_i,
    input  logic                         left_i,
    input  logic                         right_i,
    output logic                         spawn_o,
    output logic                         gameover_o,
    output tetris_ctrl_pkg::score_t      score_o,
    output tetris_geom_pkg::piece_type_t piece_type_o,
    output tetris_geom_pkg::field_t      display_o
);
    import tetris_ctrl_pkg::*;
    import tetris_geom_pkg::*;

    game_state_t state;
    logic        eval_done;
    logic        show_piece;
    field_t      piece_layer;

    board_if brd ();

    game_fsm i_fsm (
        .clk         (clk),
        .reset       (reset),
        .tick_i      (tick_i),
        .brd         (brd.ctrl),
        .eval_done_i (eval_done),
        .state_o     (state)
    );

    piece_tracker i_tracker (
        .clk          (clk),
        .reset        (reset),
        .tick_i       (tick_i),
        .left_i       (left_i),
        .right_i      (right_i),
        .state_i      (state),
        .brd          (brd.mover),
        .piece_type_o (piece_type_o)
    );

    playfield i_field (
        .clk         (clk),
        .reset       (reset),
        .state_i     (state),
        .brd         (brd.owner),
        .eval_done_o (eval_done),
        .score_o     (score_o)
    );

    assign spawn_o    = (state == SPAWN);
    assign gameover_o = (state == GAMEOVER);

    // Piece overlay only while it is still moving or just stuck
    assign show_piece  = (state == SPAWN) || (state == FALLING) || (state == STUCK);
    assign piece_layer = show_piece ? brd.piece_mask : '0;
    assign display_o   = brd.field | piece_layer;

endmodule

// File: playfield.sv
// Settled field, line clears and score
`timescale 1ns/1ps

module playfield (
    input  logic                         clk,
    input  logic                         reset,
    input  tetris_ctrl_pkg::game_state_t state_i,
    board_if.owner                       brd,
    output logic                         eval_done_o,
    output tetris_ctrl_pkg::score_t      score_o
);
    import tetris_ctrl_pkg::*;
    import tetris_geom_pkg::*;

    field_t   field_q;
    field_t   work_q;
    row_idx_t scan_row;
    score_t   score_q;
    logic     eval_done_q;
    field_t   merged;
    logic     row_full;
    logic     clear_row;

    // Drop every row above the cut by one, top row comes in empty
    function automatic field_t shift_down(field_t f, row_idx_t cut);
        field_t res;
        res = f;
        for (int r = BOARD_ROWS - 1; r > 0; r--) begin
            if (r <= int'(cut)) begin
                res[r] = f[r-1];
            end
        end
        res[0] = '0;
        return res;
    endfunction

    assign merged    = field_q | brd.piece_mask;
    assign row_full  = &work_q[scan_row];
    assign clear_row = (state_i == EVAL) && !eval_done_q && row_full;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            field_q     <= '0;
            scan_row    <= row_idx_t'(BOARD_ROWS - 1);
            score_q     <= '0;
            eval_done_q <= 1'b0;
        end else begin
            case (state_i)
                LANDED: begin
                    field_q     <= merged;
                    scan_row    <= row_idx_t'(BOARD_ROWS - 1);
                    eval_done_q <= 1'b0;
                end
                EVAL: begin
                    if (eval_done_q) begin
                        field_q     <= work_q;
                        eval_done_q <= 1'b0;
                    end else if (row_full) begin
                        // Same row is scanned again for cascades
                        if (score_q != SCORE_MAX) begin
                            score_q <= score_q + 1'b1;
                        end
                    end else if (scan_row == '0) begin
                        eval_done_q <= 1'b1;
                    end else begin
                        scan_row <= scan_row - 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_i == LANDED) begin
            work_q <= merged;
        end else if (clear_row) begin
            work_q <= shift_down(work_q, scan_row);
        end
    end

    assign brd.field   = field_q;
    assign eval_done_o = eval_done_q;
    assign score_o     = score_q;

endmodule

// File: piece_tracker.sv
// Active piece position and collision
`timescale 1ns/1ps

module piece_tracker (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         tick_i,
    input  logic                         left_i,
    input  logic                         right_i,
    input  tetris_ctrl_pkg::game_state_t state_i,
    board_if.mover                       brd,
    output tetris_geom_pkg::piece_type_t piece_type_o
);
    import tetris_ctrl_pkg::*;
    import tetris_geom_pkg::*;

    piece_type_t next_type;
    piece_type_t cur_type;
    row_idx_t    row_q;
    col_idx_t    col_q;

    logic        spawn_view;
    piece_type_t shown_type;
    row_idx_t    shown_row;
    col_idx_t    shown_col;
    field_t      mask;

    logic        edge_left;
    logic        edge_right;
    logic        over_left;
    logic        over_right;

    // Shape rows moved right by the column, then the field moved down by the row
    function automatic field_t place(piece_type_t kind, row_idx_t top, col_idx_t left);
        field_t m;
        m = '0;
        for (int r = 0; r < SHAPE_SIZE; r++) begin
            m[r] = row_t'(SHAPES[kind][r]) << left;
        end
        return m << (BOARD_COLS * int'(top));
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            next_type <= LINE;
            cur_type  <= LINE;
            row_q     <= '0;
            col_q     <= col_idx_t'(SPAWN_COL);
        end else if (tick_i) begin
            if (state_i == SPAWN) begin
                cur_type  <= next_type;
                next_type <= (next_type == T) ? LINE : piece_type_t'(next_type + 3'd1);
                row_q     <= '0;
                col_q     <= col_idx_t'(SPAWN_COL);
            end else if (state_i == FALLING && !brd.hit_bottom) begin
                row_q <= row_q + 1'b1;
                // Left wins when both are held
                if (left_i && !brd.hit_left) begin
                    col_q <= col_q - 1'b1;
                end else if (right_i && !brd.hit_right) begin
                    col_q <= col_q + 1'b1;
                end
            end
        end
    end

    // While spawning, the upcoming piece is shown at the spawn point
    assign spawn_view = (state_i == SPAWN);
    assign shown_type = spawn_view ? next_type : cur_type;
    assign shown_row  = spawn_view ? row_idx_t'(0) : row_q;
    assign shown_col  = spawn_view ? col_idx_t'(SPAWN_COL) : col_q;

    assign mask = place(shown_type, shown_row, shown_col);

    always_comb begin
        edge_left  = 1'b0;
        edge_right = 1'b0;
        over_left  = 1'b0;
        over_right = 1'b0;
        for (int r = 0; r < BOARD_ROWS; r++) begin
            edge_left  |= mask[r][0];
            edge_right |= mask[r][BOARD_COLS-1];
            over_left  |= |((mask[r] >> 1) & brd.field[r]);
            over_right |= |((mask[r] << 1) & brd.field[r]);
        end
    end

    assign brd.piece_mask = mask;
    assign brd.hit_bottom = (|mask[BOARD_ROWS-1]) || (|((mask << BOARD_COLS) & brd.field));
    assign brd.hit_left   = edge_left || over_left;
    assign brd.hit_right  = edge_right || over_right;

    assign piece_type_o = shown_type;

endmodule

// File: game_fsm.sv
// Game state sequencer
`timescale 1ns/1ps

module game_fsm (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         tick_i,
    board_if.ctrl                        brd,
    input  logic                         eval_done_i,
    output tetris_ctrl_pkg::game_state_t state_o
);
    import tetris_ctrl_pkg::*;
    import tetris_geom_pkg::*;

    game_state_t state_q;
    game_state_t state_d;
    row_t        top_row;

    assign top_row = brd.field[0];

    always_comb begin
        state_d = state_q;
        case (state_q)
            SPAWN: begin
                if (tick_i) begin
                    state_d = FALLING;
                end
            end
            FALLING: begin
                if (tick_i && brd.hit_bottom) begin
                    state_d = STUCK;
                end
            end
            STUCK: begin
                // Settled blocks in the top row end the game
                if (|top_row) begin
                    state_d = GAMEOVER;
                end else begin
                    state_d = LANDED;
                end
            end
            LANDED: begin
                state_d = EVAL;
            end
            EVAL: begin
                if (eval_done_i) begin
                    state_d = SPAWN;
                end
            end
            GAMEOVER: begin
                state_d = GAMEOVER;
            end
            default: begin
                state_d = SPAWN;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= SPAWN;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

endmodule

// File: board_if.sv
// Board signals between game blocks
`timescale 1ns/1ps

interface board_if;
    import tetris_geom_pkg::*;

    field_t field;
    field_t piece_mask;
    logic   hit_bottom;
    logic   hit_left;
    logic   hit_right;

    modport owner (
        output field,
        input  piece_mask
    );

    modport mover (
        input  field,
        output piece_mask,
        output hit_bottom,
        output hit_left,
        output hit_right
    );

    modport ctrl (
        input field,
        input hit_bottom
    );

endinterface

// File: tetris_ctrl_pkg.sv
// Game control types
package tetris_ctrl_pkg;

    typedef enum logic [2:0] {
        SPAWN    = 3'd0,
        FALLING  = 3'd1,
        STUCK    = 3'd2,
        LANDED   = 3'd3,
        EVAL     = 3'd4,
        GAMEOVER = 3'd5
    } game_state_t;

    typedef logic [7:0] score_t;

    // Score saturates here
    localparam score_t SCORE_MAX = 8'd255;

endpackage

// File: tetris_geom_pkg.sv
// Board geometry and piece shapes
package tetris_geom_pkg;

    localparam int BOARD_ROWS = 20;
    localparam int BOARD_COLS = 10;
    localparam int SPAWN_COL  = 4;
    localparam int SHAPE_SIZE = 4;
    localparam int NUM_PIECES = 7;

    // Bit c is column c
    typedef logic [BOARD_COLS-1:0] row_t;

    // Row 0 is the top of the board
    typedef row_t [BOARD_ROWS-1:0] field_t;

    typedef logic [4:0] row_idx_t;
    typedef logic [3:0] col_idx_t;

    typedef enum logic [2:0] {
        LINE   = 3'd0,
        SQUARE = 3'd1,
        L      = 3'd2,
        REV_L  = 3'd3,
        S      = 3'd4,
        Z      = 3'd5,
        T      = 3'd6
    } piece_type_t;

    // Four rows per shape, top-left of the bounding box at offset 0
    localparam logic [SHAPE_SIZE-1:0] SHAPES [NUM_PIECES][SHAPE_SIZE] = '{
        // LINE
        '{4'b0001, 4'b0001, 4'b0001, 4'b0001},
        // SQUARE
        '{4'b0011, 4'b0011, 4'b0000, 4'b0000},
        // L
        '{4'b0001, 4'b0001, 4'b0011, 4'b0000},
        // REV_L
        '{4'b0010, 4'b0010, 4'b0011, 4'b0000},
        // S
        '{4'b0110, 4'b0011, 4'b0000, 4'b0000},
        // Z
        '{4'b0011, 4'b0110, 4'b0000, 4'b0000},
        // T
        '{4'b0010, 4'b0111, 4'b0000, 4'b0000}
    };

endpackage
